// File: project.f
verilog/rv_front_pkg.sv
verilog/rv_mem_port.sv
verilog/rv_predecode.sv
verilog/rv_decode.sv
verilog/rv_front.sv
verif/rv_front_props.sv
verif/rv_front_tb.sv

// File: Bender.yml
package:
  name: rv_front

sources:
  - verilog/rv_front_pkg.sv
  - verilog/rv_mem_port.sv
  - verilog/rv_predecode.sv
  - verilog/rv_decode.sv
  - verilog/rv_front.sv
  - target: simulation
    files:
      - verif/rv_front_props.sv
      - verif/rv_front_tb.sv

// File: verif/rv_front_tb.sv
`timescale 1ns/1ps

module rv_front_tb;

	localparam int CLK_PERIOD = 8;
	localparam int TIMEOUT = 200;
	localparam logic [1:0] K_FETCH = 2'd0;
	localparam logic [1:0] K_READ = 2'd1;
	localparam logic [1:0] K_WRITE = 2'd2;

	typedef struct packed {
		logic [1:0]             kind;
		rv_front_pkg::xlen_t    addr;
		rv_front_pkg::xlen_t    word;
		rv_front_pkg::wstrb_t   wstrb;
		rv_front_pkg::xlen_t    exp; // Read word or merged memory word
		rv_front_pkg::insn_op_e op;
		rv_front_pkg::reg_idx_t rd;
		rv_front_pkg::reg_idx_t rs1;
		rv_front_pkg::reg_idx_t rs2;
		rv_front_pkg::xlen_t    imm;
	} entry_t;

	logic                   clk = 1'b0;
	logic                   resetn;
	rv_front_pkg::mem_req_t req;
	logic                   mem_ready;
	rv_front_pkg::xlen_t    mem_rdata;
	rv_front_pkg::mem_bus_t bus;
	logic                   mem_done;
	rv_front_pkg::xlen_t    rdata_word;
	rv_front_pkg::decoded_t decoded;
	logic                   decoded_valid;
	logic                   insn_trap;

	rv_front_pkg::xlen_t mem [0:63];
	integer seed = 32'h041ea950;
	entry_t table_q[$];
	string names[$];
	int done_count = 0;
	int fetch_pc = 0;

	rv_front i_dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		#1;
		mem_ready = ($random(seed) & 3) != 0; // Stall about one cycle in four
	end

	assign mem_rdata = mem[bus.addr[7:2]];

	always @(posedge clk) begin
		if (resetn && bus.valid && mem_ready) begin
			for (int b = 0; b < 4; b++) begin
				if (bus.wstrb[b])
					mem[bus.addr[7:2]][8*b +: 8] = bus.wdata[8*b +: 8];
			end
		end
	end

	always @(negedge clk) begin
		if (mem_done)
			done_count++;
	end

	always @(negedge clk) begin
		if (i_dut.i_mem_port.i_props.fail_count != 0)
			report_failure("a bus assertion failed");
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			report_failure($sformatf("mismatch %s expected %h actual %h",
				name, expected, actual));
	endtask

	// Fetches sit back to back from pc 0, the low address bits vary
	function automatic void add_insn(string name, rv_front_pkg::insn_t word,
			rv_front_pkg::insn_op_e op, rv_front_pkg::reg_idx_t rd,
			rv_front_pkg::reg_idx_t rs1, rv_front_pkg::reg_idx_t rs2,
			rv_front_pkg::xlen_t imm);
		entry_t e;
		e = '0;
		e.kind = K_FETCH;
		e.addr = 32'(fetch_pc + table_q.size() % 4);
		e.word = word;
		e.exp = word;
		e.op = op;
		e.rd = rd;
		e.rs1 = rs1;
		e.rs2 = rs2;
		e.imm = imm;
		fetch_pc += 4;
		table_q.push_back(e);
		names.push_back(name);
	endfunction

	function automatic void add_data(string name, logic [1:0] kind, rv_front_pkg::xlen_t addr,
			rv_front_pkg::xlen_t wdata, rv_front_pkg::wstrb_t wstrb, rv_front_pkg::xlen_t exp);
		entry_t e;
		e = '0;
		e.kind = kind;
		e.addr = addr;
		e.word = wdata;
		e.wstrb = wstrb;
		e.exp = exp;
		table_q.push_back(e);
		names.push_back(name);
	endfunction

	task automatic load_table();
		add_insn("lui", 32'h123452b7, rv_front_pkg::OP_LUI, 5, 8, 3, 32'h12345000);
		add_insn("auipc", 32'hfffff517, rv_front_pkg::OP_AUIPC, 10, 31, 31, 32'hfffff000);
		add_insn("jal_back", 32'hffdff0ef, rv_front_pkg::OP_JAL, 1, 31, 29, 32'hfffffffc);
		add_insn("jal_fwd", 32'h005811ef, rv_front_pkg::OP_JAL, 3, 16, 5, 32'h00081804);
		add_insn("jalr", 32'h010100e7, rv_front_pkg::OP_JALR, 1, 2, 16, 32'h00000010);
		add_data("read_fill", K_READ, 32'h86, 32'h0, 4'h0, 32'hc0de0084);
		add_insn("bne", 32'hfe629ce3, rv_front_pkg::OP_BNE, 25, 5, 6, 32'hfffffff8);
		add_insn("beq", 32'h000000e3, rv_front_pkg::OP_BEQ, 1, 0, 0, 32'h00000800);
		add_insn("lw", 32'hffc42383, rv_front_pkg::OP_LW, 7, 8, 28, 32'hfffffffc);
		add_data("write_low", K_WRITE, 32'h8b, 32'h11223344, 4'b0101, 32'hc0220044);
		add_data("read_low", K_READ, 32'h88, 32'h0, 4'h0, 32'hc0220044);
		add_insn("sw", 32'h00b62a23, rv_front_pkg::OP_SW, 20, 12, 11, 32'h00000014);
		add_insn("sb", 32'hfe110fa3, rv_front_pkg::OP_SB, 31, 2, 1, 32'hffffffff);
		add_insn("addi", 32'h80010093, rv_front_pkg::OP_ADDI, 1, 2, 0, 32'hfffff800);
		add_insn("andi", 32'h7ff27193, rv_front_pkg::OP_ANDI, 3, 4, 31, 32'h000007ff);
		add_insn("slli", 32'h00331293, rv_front_pkg::OP_SLLI, 5, 6, 3, 32'h00000003);
		add_insn("srai", 32'h41f45393, rv_front_pkg::OP_SRAI, 7, 8, 31, 32'h0000041f);
		add_data("write_high", K_WRITE, 32'h90, 32'h55667788, 4'b1010, 32'h55de7790);
		add_data("read_high", K_READ, 32'h93, 32'h0, 4'h0, 32'h55de7790);
		add_insn("add", 32'h003100b3, rv_front_pkg::OP_ADD, 1, 2, 3, 32'h0);
		add_insn("sub", 32'h40628233, rv_front_pkg::OP_SUB, 4, 5, 6, 32'h0);
		add_insn("sra", 32'h409453b3, rv_front_pkg::OP_SRA, 7, 8, 9, 32'h0);
		add_insn("sltu", 32'h00c5b533, rv_front_pkg::OP_SLTU, 10, 11, 12, 32'h0);
		add_insn("ecall", 32'h00000073, rv_front_pkg::OP_ECALL_EBREAK, 0, 0, 0, 32'h0);
		add_insn("ebreak", 32'h00100073, rv_front_pkg::OP_ECALL_EBREAK, 0, 0, 1, 32'h0);
		add_data("write_full", K_WRITE, 32'h9c, 32'haabbccdd, 4'hf, 32'haabbccdd);
		add_data("read_full", K_READ, 32'h9e, 32'h0, 4'h0, 32'haabbccdd);
		add_insn("all_zero", 32'h00000000, rv_front_pkg::OP_ILLEGAL, 0, 0, 0, 32'h0);
		add_insn("bad_opcode", 32'hffffffff, rv_front_pkg::OP_ILLEGAL, 31, 31, 31, 32'h0);
		add_insn("bad_branch", 32'h00002063, rv_front_pkg::OP_ILLEGAL, 0, 0, 0, 32'h0);
		add_insn("bad_funct7", 32'h20000033, rv_front_pkg::OP_ILLEGAL, 0, 0, 0, 32'h0);
	endtask

	task automatic run_access(input int idx);
		entry_t e;
		string name;
		int cycles;
		e = table_q[idx];
		name = names[idx];
		@(posedge clk);
		#1;
		check_value({name, ".done_count"}, idx, done_count);
		req.addr = e.addr;
		req.wdata = e.word;
		req.wstrb = e.wstrb;
		req.rinst = e.kind == K_FETCH;
		req.rdata = e.kind == K_READ;
		req.wdata_en = e.kind == K_WRITE;
		cycles = 0;
		@(negedge clk);
		while (!mem_done) begin
			cycles++;
			if (cycles >= TIMEOUT)
				report_failure({"timeout waiting for mem_done in ", name});
			@(negedge clk);
		end
		check_value({name, ".instr"}, e.kind == K_FETCH, bus.instr);
		check_value({name, ".addr"}, e.addr & 32'hfffffffc, bus.addr);
		check_value({name, ".wstrb"}, (e.kind == K_WRITE) ? e.wstrb : 4'h0, bus.wstrb);
		if (e.kind == K_WRITE)
			check_value({name, ".wdata"}, e.word, bus.wdata);
		else
			check_value({name, ".rdata_word"}, e.exp, rdata_word);
		@(posedge clk);
		#1;
		req.rinst = 1'b0;
		req.rdata = 1'b0;
		req.wdata_en = 1'b0;
		if (e.kind == K_WRITE)
			check_value({name, ".memory"}, e.exp, mem[e.addr[7:2]]);
		else
			check_value({name, ".rdata_hold"}, e.exp, rdata_word);
		if (e.kind == K_FETCH) begin
			cycles = 0;
			do begin
				@(negedge clk);
				cycles++;
				if (cycles >= TIMEOUT)
					report_failure({"timeout waiting for decoded_valid in ", name});
			end while (!decoded_valid);
			check_value({name, ".latency"}, 2, cycles); // Counted from the done cycle
			check_value({name, ".op"}, e.op, decoded.op);
			check_value({name, ".rd"}, e.rd, decoded.rd);
			check_value({name, ".rs1"}, e.rs1, decoded.rs1);
			check_value({name, ".rs2"}, e.rs2, decoded.rs2);
			check_value({name, ".imm"}, e.imm, decoded.imm);
			check_value({name, ".trap"}, e.op == rv_front_pkg::OP_ILLEGAL, insn_trap);
		end
	endtask

	initial begin
		resetn = 1'b0;
		req = '0;
		mem_ready = 1'b0;
		load_table();
		for (int i = 0; i < 64; i++)
			mem[i] = 32'hc0de0000 | 32'(i << 2); // Word carries its own address
		foreach (table_q[i]) begin
			if (table_q[i].kind == K_FETCH)
				mem[table_q[i].addr[7:2]] = table_q[i].word;
		end
		repeat (5) @(posedge clk);
		#1;
		resetn = 1'b1;
		@(negedge clk);
		check_value("reset.valid", 1'b0, bus.valid);
		check_value("reset.mem_done", 1'b0, mem_done);
		check_value("reset.decoded_valid", 1'b0, decoded_valid);
		check_value("reset.insn_trap", 1'b0, insn_trap);
		foreach (table_q[i])
			run_access(i);
		@(posedge clk);
		#1;
		check_value("final.done_count", table_q.size(), done_count);
		if (i_dut.i_mem_port.i_props.fail_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			report_failure("bus assertions failed during the run");
		end
	end

endmodule

// File: verif/rv_front_props.sv
`timescale 1ns/1ps

module rv_front_props (
	input logic                     clk,
	input logic                     resetn,
	input rv_front_pkg::mem_req_t   req,
	input logic                     mem_ready,
	input rv_front_pkg::mem_bus_t   bus,
	input rv_front_pkg::mem_state_e state
);

	int unsigned fail_count = 0; // Failed assertion count

	// Stalled transfer keeps the bus unchanged
	valid_hold: assert property (@(posedge clk) disable iff (!resetn)
		bus.valid && !mem_ready |=> bus.valid && $stable(bus))
	else begin
		$error("bus.valid dropped or bus fields changed before ready");
		fail_count++;
	end

	read_no_strobe: assert property (@(posedge clk) disable iff (!resetn)
		state != rv_front_pkg::MEM_WRITE |-> bus.wstrb == '0)
	else begin
		$error("bus.wstrb is nonzero outside of a write");
		fail_count++;
	end

	one_request: assert property (@(posedge clk) disable iff (!resetn)
		$onehot0({req.rinst, req.rdata, req.wdata_en}))
	else begin
		$error("more than one request level is high");
		fail_count++;
	end

endmodule

bind rv_mem_port rv_front_props i_props (
	.clk       (clk),
	.resetn    (resetn),
	.req       (req),
	.mem_ready (mem_ready),
	.bus       (bus),
	.state     (state)
);

// File: verilog/rv_front.sv
`timescale 1ns/1ps

module rv_front (
	input  logic                   clk,
	input  logic                   resetn,
	input  rv_front_pkg::mem_req_t req,
	input  logic                   mem_ready,
	input  rv_front_pkg::xlen_t    mem_rdata,
	output rv_front_pkg::mem_bus_t bus,
	output logic                   mem_done,
	output rv_front_pkg::xlen_t    rdata_word,
	output rv_front_pkg::decoded_t decoded,
	output logic                   decoded_valid,
	output logic                   insn_trap
);

	logic                   fetch_done;
	logic                   decode_trigger;
	rv_front_pkg::opgroup_t groups;
	rv_front_pkg::insn_t    insn_q;
	rv_front_pkg::reg_idx_t rd;
	rv_front_pkg::reg_idx_t rs1;
	rv_front_pkg::reg_idx_t rs2;
	rv_front_pkg::xlen_t    imm_uj;

	rv_mem_port i_mem_port (
		.clk        (clk),
		.resetn     (resetn),
		.req        (req),
		.mem_ready  (mem_ready),
		.mem_rdata  (mem_rdata),
		.bus        (bus),
		.mem_done   (mem_done),
		.fetch_done (fetch_done),
		.rdata_word (rdata_word)
	);

	rv_predecode i_predecode (
		.clk            (clk),
		.resetn         (resetn),
		.fetch_done     (fetch_done),
		.rdata_word     (rdata_word),
		.groups         (groups),
		.insn_q         (insn_q),
		.rd             (rd),
		.rs1            (rs1),
		.rs2            (rs2),
		.imm_uj         (imm_uj),
		.decode_trigger (decode_trigger)
	);

	rv_decode i_decode (
		.clk            (clk),
		.resetn         (resetn),
		.decode_trigger (decode_trigger),
		.groups         (groups),
		.insn_q         (insn_q),
		.rd             (rd),
		.rs1            (rs1),
		.rs2            (rs2),
		.imm_uj         (imm_uj),
		.decoded        (decoded),
		.decoded_valid  (decoded_valid),
		.insn_trap      (insn_trap)
	);

endmodule

// File: verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   decode_trigger,
	input  rv_front_pkg::opgroup_t groups,
	input  rv_front_pkg::insn_t    insn_q,
	input  rv_front_pkg::reg_idx_t rd,
	input  rv_front_pkg::reg_idx_t rs1,
	input  rv_front_pkg::reg_idx_t rs2,
	input  rv_front_pkg::xlen_t    imm_uj,
	output rv_front_pkg::decoded_t decoded,
	output logic                   decoded_valid,
	output logic                   insn_trap
);

	rv_front_pkg::opcode_t opcode;
	rv_front_pkg::funct3_t funct3;
	logic f7_base;
	logic f7_alt;
	rv_front_pkg::insn_op_e next_op;
	rv_front_pkg::xlen_t next_imm;

	assign opcode = insn_q[6:0];
	assign funct3 = insn_q[14:12];
	assign f7_base = insn_q[31:25] == rv_front_pkg::F7_BASE;
	assign f7_alt = insn_q[31:25] == rv_front_pkg::F7_ALT;

	always_comb begin
		next_op = rv_front_pkg::OP_ILLEGAL;
		if (groups.lui_auipc_jal) begin
			if (opcode == rv_front_pkg::OPC_LUI)
				next_op = rv_front_pkg::OP_LUI;
			else if (opcode == rv_front_pkg::OPC_AUIPC)
				next_op = rv_front_pkg::OP_AUIPC;
			else
				next_op = rv_front_pkg::OP_JAL;
		end else if (groups.jalr) begin
			if (funct3 == 3'b000)
				next_op = rv_front_pkg::OP_JALR;
		end else if (groups.branch) begin
			case (funct3)
				3'b000: next_op = rv_front_pkg::OP_BEQ;
				3'b001: next_op = rv_front_pkg::OP_BNE;
				3'b100: next_op = rv_front_pkg::OP_BLT;
				3'b101: next_op = rv_front_pkg::OP_BGE;
				3'b110: next_op = rv_front_pkg::OP_BLTU;
				3'b111: next_op = rv_front_pkg::OP_BGEU;
				default: next_op = rv_front_pkg::OP_ILLEGAL;
			endcase
		end else if (groups.load) begin
			case (funct3)
				3'b000: next_op = rv_front_pkg::OP_LB;
				3'b001: next_op = rv_front_pkg::OP_LH;
				3'b010: next_op = rv_front_pkg::OP_LW;
				3'b100: next_op = rv_front_pkg::OP_LBU;
				3'b101: next_op = rv_front_pkg::OP_LHU;
				default: next_op = rv_front_pkg::OP_ILLEGAL;
			endcase
		end else if (groups.store) begin
			case (funct3)
				3'b000: next_op = rv_front_pkg::OP_SB;
				3'b001: next_op = rv_front_pkg::OP_SH;
				3'b010: next_op = rv_front_pkg::OP_SW;
				default: next_op = rv_front_pkg::OP_ILLEGAL;
			endcase
		end else if (groups.alu_imm) begin
			case (funct3)
				3'b000: next_op = rv_front_pkg::OP_ADDI;
				3'b010: next_op = rv_front_pkg::OP_SLTI;
				3'b011: next_op = rv_front_pkg::OP_SLTIU;
				3'b100: next_op = rv_front_pkg::OP_XORI;
				3'b110: next_op = rv_front_pkg::OP_ORI;
				3'b111: next_op = rv_front_pkg::OP_ANDI;
				3'b001: if (f7_base) next_op = rv_front_pkg::OP_SLLI;
				default: begin // Right shifts
					if (f7_base)
						next_op = rv_front_pkg::OP_SRLI;
					else if (f7_alt)
						next_op = rv_front_pkg::OP_SRAI;
				end
			endcase
		end else if (groups.alu_reg) begin
			if (f7_base) begin
				case (funct3)
					3'b000: next_op = rv_front_pkg::OP_ADD;
					3'b001: next_op = rv_front_pkg::OP_SLL;
					3'b010: next_op = rv_front_pkg::OP_SLT;
					3'b011: next_op = rv_front_pkg::OP_SLTU;
					3'b100: next_op = rv_front_pkg::OP_XOR;
					3'b101: next_op = rv_front_pkg::OP_SRL;
					3'b110: next_op = rv_front_pkg::OP_OR;
					default: next_op = rv_front_pkg::OP_AND;
				endcase
			end else if (f7_alt && funct3 == 3'b000) begin
				next_op = rv_front_pkg::OP_SUB;
			end else if (f7_alt && funct3 == 3'b101) begin
				next_op = rv_front_pkg::OP_SRA;
			end
		end else if (groups.system) begin
			// Only bit 20 may differ between the two
			if (insn_q[31:21] == '0 && insn_q[19:7] == '0)
				next_op = rv_front_pkg::OP_ECALL_EBREAK;
		end
	end

	always_comb begin
		next_imm = '0;
		if (groups.lui_auipc_jal) begin
			if (opcode == rv_front_pkg::OPC_JAL)
				next_imm = imm_uj;
			else
				next_imm = {insn_q[31:12], 12'b0};
		end else if (groups.jalr || groups.load || groups.alu_imm) begin
			next_imm = {{20{insn_q[31]}}, insn_q[31:20]};
		end else if (groups.store) begin
			next_imm = {{20{insn_q[31]}}, insn_q[31:25], insn_q[11:7]};
		end else if (groups.branch) begin
			next_imm = {{19{insn_q[31]}}, insn_q[31], insn_q[7], insn_q[30:25], insn_q[11:8], 1'b0};
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			decoded_valid <= 1'b0;
			insn_trap <= 1'b0;
		end else begin
			decoded_valid <= decode_trigger;
			insn_trap <= decode_trigger && (next_op == rv_front_pkg::OP_ILLEGAL);
		end
	end

	always_ff @(posedge clk) begin
		if (decode_trigger) begin
			decoded <= '{op: next_op, rd: rd, rs1: rs1, rs2: rs2, imm: next_imm};
		end
	end

endmodule

// File: verilog/rv_predecode.sv
`timescale 1ns/1ps

module rv_predecode (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   fetch_done,
	input  rv_front_pkg::xlen_t    rdata_word,
	output rv_front_pkg::opgroup_t groups,
	output rv_front_pkg::insn_t    insn_q,
	output rv_front_pkg::reg_idx_t rd,
	output rv_front_pkg::reg_idx_t rs1,
	output rv_front_pkg::reg_idx_t rs2,
	output rv_front_pkg::xlen_t    imm_uj,
	output logic                   decode_trigger
);

	rv_front_pkg::opcode_t opcode;
	rv_front_pkg::opgroup_t next_groups;
	rv_front_pkg::xlen_t jal_imm;

	assign opcode = rdata_word[6:0];

	always_comb begin
		next_groups = '0;
		next_groups.lui_auipc_jal = (opcode == rv_front_pkg::OPC_LUI) ||
			(opcode == rv_front_pkg::OPC_AUIPC) ||
			(opcode == rv_front_pkg::OPC_JAL);
		next_groups.jalr    = opcode == rv_front_pkg::OPC_JALR;
		next_groups.branch  = opcode == rv_front_pkg::OPC_BRANCH;
		next_groups.load    = opcode == rv_front_pkg::OPC_LOAD;
		next_groups.store   = opcode == rv_front_pkg::OPC_STORE;
		next_groups.alu_imm = opcode == rv_front_pkg::OPC_OP_IMM;
		next_groups.alu_reg = opcode == rv_front_pkg::OPC_OP;
		next_groups.system  = opcode == rv_front_pkg::OPC_SYSTEM;
	end

	// J-type bit order is imm[20|10:1|11|19:12]
	assign jal_imm = {
		{12{rdata_word[31]}},
		rdata_word[19:12],
		rdata_word[20],
		rdata_word[30:21],
		1'b0
	};

	always_ff @(posedge clk) begin
		if (!resetn) begin
			groups <= '0;
			decode_trigger <= 1'b0;
		end else begin
			decode_trigger <= fetch_done;
			if (fetch_done) begin
				groups <= next_groups; // All zero for an unknown opcode
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_done) begin
			insn_q <= rdata_word;
			rd <= rdata_word[11:7];
			rs1 <= rdata_word[19:15];
			rs2 <= rdata_word[24:20];
			imm_uj <= jal_imm;
		end
	end

endmodule

// File: verilog/rv_mem_port.sv
`timescale 1ns/1ps

module rv_mem_port (
	input  logic                   clk,
	input  logic                   resetn,
	input  rv_front_pkg::mem_req_t req,
	input  logic                   mem_ready,
	input  rv_front_pkg::xlen_t    mem_rdata,
	output rv_front_pkg::mem_bus_t bus,
	output logic                   mem_done,
	output logic                   fetch_done,
	output rv_front_pkg::xlen_t    rdata_word
);

	rv_front_pkg::mem_state_e state;

	logic                 valid_q;
	logic                 instr_q;
	rv_front_pkg::xlen_t  addr_q;
	rv_front_pkg::xlen_t  wdata_q;
	rv_front_pkg::wstrb_t wstrb_q;
	rv_front_pkg::xlen_t  rdata_q;

	logic read_req;
	logic start;
	logic xfer;
	logic read_done;

	assign read_req = req.rinst || req.rdata;
	assign start = (state == rv_front_pkg::MEM_IDLE) && (read_req || req.wdata_en);
	assign xfer = valid_q && mem_ready;

	assign mem_done = xfer && (state != rv_front_pkg::MEM_IDLE);
	assign fetch_done = mem_done && req.rinst;
	assign read_done = mem_done && (state == rv_front_pkg::MEM_READ);

	// Returned word is visible already in the transfer cycle
	assign rdata_word = read_done ? mem_rdata : rdata_q;

	assign bus = '{
		valid: valid_q,
		instr: instr_q,
		addr:  addr_q,
		wdata: wdata_q,
		wstrb: wstrb_q
	};

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= rv_front_pkg::MEM_IDLE;
			valid_q <= 1'b0;
			wstrb_q <= '0;
		end else begin
			case (state)
				rv_front_pkg::MEM_IDLE: begin
					if (read_req) begin
						valid_q <= 1'b1;
						wstrb_q <= '0; // Reads never drive strobes
						state <= rv_front_pkg::MEM_READ;
					end else if (req.wdata_en) begin
						valid_q <= 1'b1;
						wstrb_q <= req.wstrb;
						state <= rv_front_pkg::MEM_WRITE;
					end
				end
				rv_front_pkg::MEM_READ,
				rv_front_pkg::MEM_WRITE: begin
					// Hold everything until the slave takes it
					if (xfer) begin
						valid_q <= 1'b0;
						wstrb_q <= '0;
						state <= rv_front_pkg::MEM_IDLE;
					end
				end
				default: begin
					valid_q <= 1'b0;
					state <= rv_front_pkg::MEM_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			instr_q <= req.rinst;
			addr_q <= {req.addr[31:2], 2'b00}; // Word aligned
			wdata_q <= req.wdata;
		end
		if (read_done) begin
			rdata_q <= mem_rdata;
		end
	end

endmodule

// File: verilog/rv_front_pkg.sv
package rv_front_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [31:0] insn_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  wstrb_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;

	// RV32I major opcodes
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_SYSTEM = 7'b1110011;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_READ,
		MEM_WRITE
	} mem_state_e;

	typedef enum logic [5:0] {
		OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
		OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
		OP_SB, OP_SH, OP_SW,
		OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
		OP_SLLI, OP_SRLI, OP_SRAI,
		OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
		OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
		OP_ECALL_EBREAK,
		OP_ILLEGAL
	} insn_op_e;

	// One flag per major opcode class
	typedef struct packed {
		logic lui_auipc_jal;
		logic jalr;
		logic branch;
		logic load;
		logic store;
		logic alu_imm;
		logic alu_reg;
		logic system;
	} opgroup_t;

	typedef struct packed {
		logic   valid;
		logic   instr;
		xlen_t  addr;
		xlen_t  wdata;
		wstrb_t wstrb;
	} mem_bus_t;

	typedef struct packed {
		logic   rinst;    // Instruction fetch level
		logic   rdata;    // Data read level
		logic   wdata_en; // Data write level
		xlen_t  addr;
		xlen_t  wdata;
		wstrb_t wstrb;
	} mem_req_t;

	typedef struct packed {
		insn_op_e op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		xlen_t    imm;
	} decoded_t;

endpackage
